// ==== common/hazard_config.svh ====
`ifndef HAZARD_CONFIG_SVH
`define HAZARD_CONFIG_SVH

// register file banking
`define NUM_BANKS    8
`define BANK_PTR_W   3
`define BCNT_W       4

// vector register index
`define REG_IDX_W    5

// functional unit pipeline depths
`define INT_STAGES   1
`define IMUL_STAGES  2

// sequencer to expander
`define EXPAND_DELAY 2

`endif

// ==== common/hazard_pkg.sv ====
`default_nettype none

`include "hazard_config.svh"

package hazard_pkg;

  typedef enum logic [1:0] {
    OP_VIU  = 2'd0,
    OP_VAU0 = 2'd1,
    OP_VLU  = 2'd2,
    OP_VSU  = 2'd3
  } unit_op_e;

  typedef logic [`BANK_PTR_W-1:0] bank_ptr_t;
  typedef logic [`NUM_BANKS-1:0]  bank_vec_t;
  typedef logic [`REG_IDX_W-1:0]  reg_idx_t;

  typedef struct packed {
    logic     valid;
    unit_op_e op;
    reg_idx_t vs;
    reg_idx_t vt;
    reg_idx_t vd;
  } issue_req_t;

  // all pointers already reduced modulo the active bank count
  typedef struct packed {
    bank_ptr_t cur;
    bank_ptr_t plus1;
    bank_ptr_t plus2;
    bank_ptr_t plus3;
    bank_ptr_t plus4;
    bank_ptr_t viu_wptr;
    bank_ptr_t vau0_wptr;
  } ring_ptrs_t;

  typedef struct packed {
    logic lane_rlast;
    logic lane_wlast;
    logic expand_wen;
    logic seq_last;
  } retire_t;

  typedef struct packed {
    bank_vec_t val;
    bank_vec_t vau0;
    bank_vec_t vsu;
  } rport_state_t;

  typedef struct packed {
    bank_vec_t                      val;
    bank_vec_t                      head;
    bank_vec_t                      vau0;
    bank_vec_t                      vlu;
    reg_idx_t [`NUM_BANKS-1:0]      tags;
  } wport_state_t;

endpackage

`default_nettype wire

// ==== verilog/bank_ring.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hazard_config.svh"

module bank_ring
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`BCNT_W-1:0]     bcnt,
  output hazard_pkg::ring_ptrs_t ptrs
);

  // write-back distance per unit, in banks
  localparam logic [`BCNT_W:0] VIU_WOFF  = `INT_STAGES + 1 + `EXPAND_DELAY;
  localparam logic [`BCNT_W:0] VAU0_WOFF = `IMUL_STAGES + 2 + `EXPAND_DELAY;

  hazard_pkg::bank_ptr_t cur_q;

  // (cur + off) mod cnt, off is small enough that two subtractions cover it
  function automatic hazard_pkg::bank_ptr_t wrap
  (
    input hazard_pkg::bank_ptr_t cur,
    input logic [`BCNT_W:0]      off,
    input logic [`BCNT_W-1:0]    cnt
  );
    logic [`BCNT_W:0] sum;
    logic [`BCNT_W:0] once;
    logic [`BCNT_W:0] twice;
    sum   = {{(`BCNT_W+1-`BANK_PTR_W){1'b0}}, cur} + off;
    once  = sum - {1'b0, cnt};
    twice = once - {1'b0, cnt};
    if (sum < {1'b0, cnt})
      wrap = sum[`BANK_PTR_W-1:0];
    else if (once < {1'b0, cnt})
      wrap = once[`BANK_PTR_W-1:0];
    else
      wrap = twice[`BANK_PTR_W-1:0];
  endfunction

  always_comb
  begin
    ptrs.cur       = cur_q;
    ptrs.plus1     = wrap(cur_q, 1, bcnt);
    ptrs.plus2     = wrap(cur_q, 2, bcnt);
    ptrs.plus3     = wrap(cur_q, 3, bcnt);
    ptrs.plus4     = wrap(cur_q, 4, bcnt);
    ptrs.viu_wptr  = wrap(cur_q, VIU_WOFF, bcnt);
    ptrs.vau0_wptr = wrap(cur_q, VAU0_WOFF, bcnt);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      cur_q <= '0;
    else
      cur_q <= ptrs.plus1;
  end

  // the pointer math above relies on this
  a_bcnt_range: assert property (
    @(posedge clk) disable iff (reset)
    (bcnt >= 4) && (bcnt <= `NUM_BANKS)
  ) else $error("bcnt %0d outside the supported range", bcnt);

endmodule

`default_nettype wire

// ==== reservation/rport_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module rport_table
(
  input  logic                     clk,
  input  logic                     reset,
  input  hazard_pkg::ring_ptrs_t   ptrs,
  input  logic                     fire,
  input  hazard_pkg::unit_op_e     op,
  input  logic                     rlast,
  output hazard_pkg::rport_state_t state
);

  hazard_pkg::rport_state_t state_d;

  always_comb
  begin
    state_d = state;

    if (fire)
    begin
      case (op)
        hazard_pkg::OP_VIU:
        begin
          state_d.val[ptrs.plus2] = 1'b1;
        end
        hazard_pkg::OP_VAU0:
        begin
          // two operands, two consecutive banks
          state_d.val[ptrs.plus2]  = 1'b1;
          state_d.vau0[ptrs.plus2] = 1'b1;
          state_d.val[ptrs.plus3]  = 1'b1;
          state_d.vau0[ptrs.plus3] = 1'b1;
        end
        hazard_pkg::OP_VSU:
        begin
          state_d.val[ptrs.plus2] = 1'b1;
          state_d.vsu[ptrs.plus2] = 1'b1;
        end
        default:
        begin
          // vlu reads no register
        end
      endcase
    end

    if (rlast)
    begin
      state_d.val[ptrs.cur]  = 1'b0;
      state_d.vau0[ptrs.cur] = 1'b0;
      state_d.vsu[ptrs.cur]  = 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= '0;
    else
      state <= state_d;
  end

  // structural checks in issue_check keep one op per unit in flight
  a_one_vau0: assert property (
    @(posedge clk) disable iff (reset)
    $countones(state.vau0) <= 2
  ) else $error("more than one vau0 holds read ports");

  a_one_vsu: assert property (
    @(posedge clk) disable iff (reset)
    $countones(state.vsu) <= 1
  ) else $error("more than one vsu holds a read port");

  a_rlast_hit: assert property (
    @(posedge clk) disable iff (reset)
    rlast |-> state.val[ptrs.cur]
  ) else $error("lane_rlast on empty read bank %0d", ptrs.cur);

endmodule

`default_nettype wire

// ==== reservation/wport_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hazard_config.svh"

module wport_table
(
  input  logic                     clk,
  input  logic                     reset,
  input  hazard_pkg::ring_ptrs_t   ptrs,
  input  logic                     fire,
  input  hazard_pkg::unit_op_e     op,
  input  hazard_pkg::reg_idx_t     vd,
  input  logic                     expand_wen,
  input  logic                     wlast,
  output hazard_pkg::wport_state_t state
);

  hazard_pkg::bank_vec_t val_q;
  hazard_pkg::bank_vec_t head_q;
  hazard_pkg::bank_vec_t vau0_q;
  hazard_pkg::bank_vec_t vlu_q;
  hazard_pkg::bank_vec_t val_d;
  hazard_pkg::bank_vec_t head_d;
  hazard_pkg::bank_vec_t vau0_d;
  hazard_pkg::bank_vec_t vlu_d;
  hazard_pkg::reg_idx_t  tag_q [`NUM_BANKS];
  hazard_pkg::bank_ptr_t wptr;
  logic                  wr_en;

  // store has no destination
  always_comb
  begin
    wr_en = fire && (op != hazard_pkg::OP_VSU);
    case (op)
      hazard_pkg::OP_VIU:  wptr = ptrs.viu_wptr;
      hazard_pkg::OP_VAU0: wptr = ptrs.vau0_wptr;
      default:             wptr = ptrs.plus2;
    endcase
  end

  always_comb
  begin
    val_d  = val_q;
    head_d = head_q;
    vau0_d = vau0_q;
    vlu_d  = vlu_q;

    if (wr_en)
    begin
      val_d[wptr]  = 1'b1;
      head_d[wptr] = 1'b1;
      vau0_d[wptr] = (op == hazard_pkg::OP_VAU0);
      vlu_d[wptr]  = (op == hazard_pkg::OP_VLU);
    end

    // first element written, later readers may chain
    if (expand_wen)
      head_d[ptrs.cur] = 1'b0;

    if (wlast)
    begin
      val_d[ptrs.cur]  = 1'b0;
      head_d[ptrs.cur] = 1'b0;
      vau0_d[ptrs.cur] = 1'b0;
      vlu_d[ptrs.cur]  = 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      val_q  <= '0;
      head_q <= '0;
      vau0_q <= '0;
      vlu_q  <= '0;
    end
    else
    begin
      val_q  <= val_d;
      head_q <= head_d;
      vau0_q <= vau0_d;
      vlu_q  <= vlu_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      tag_q[wptr] <= vd;
  end

  always_comb
  begin
    state.val  = val_q;
    state.head = head_q;
    state.vau0 = vau0_q;
    state.vlu  = vlu_q;
    for (int i = 0; i < `NUM_BANKS; i++)
      state.tags[i] = tag_q[i];
  end

  a_one_vau0: assert property (
    @(posedge clk) disable iff (reset)
    $countones(vau0_q) <= 1
  ) else $error("more than one vau0 holds a write port");

  a_one_vlu: assert property (
    @(posedge clk) disable iff (reset)
    $countones(vlu_q) <= 1
  ) else $error("more than one vlu holds a write port");

  a_wlast_hit: assert property (
    @(posedge clk) disable iff (reset)
    wlast |-> val_q[ptrs.cur]
  ) else $error("lane_wlast on empty write bank %0d", ptrs.cur);

  a_wen_hit: assert property (
    @(posedge clk) disable iff (reset)
    expand_wen |-> val_q[ptrs.cur]
  ) else $error("expand_wen on empty write bank %0d", ptrs.cur);

endmodule

`default_nettype wire

// ==== reservation/seq_slot_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module seq_slot_table
(
  input  logic                   clk,
  input  logic                   reset,
  input  hazard_pkg::ring_ptrs_t ptrs,
  input  logic                   fire,
  input  logic                   seq_last,
  output hazard_pkg::bank_vec_t  slots
);

  hazard_pkg::bank_vec_t slots_d;

  // every unit takes exactly one slot, right after cur
  always_comb
  begin
    slots_d = slots;
    if (fire)
      slots_d[ptrs.plus1] = 1'b1;
    if (seq_last)
      slots_d[ptrs.cur] = 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      slots <= '0;
    else
      slots <= slots_d;
  end

endmodule

`default_nettype wire

// ==== verilog/issue_check.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hazard_config.svh"

module issue_check
(
  input  hazard_pkg::issue_req_t   req,
  input  hazard_pkg::ring_ptrs_t   ptrs,
  input  hazard_pkg::rport_state_t rstate,
  input  hazard_pkg::wport_state_t wstate,
  input  hazard_pkg::bank_vec_t    slots,
  output logic                     ready,
  output logic                     fire,
  output hazard_pkg::unit_op_e     op,
  output hazard_pkg::reg_idx_t     vd
);

  hazard_pkg::bank_vec_t pend;
  hazard_pkg::bank_vec_t hit_vs;
  hazard_pkg::bank_vec_t hit_vt;
  hazard_pkg::bank_vec_t hit_vd;
  logic                  raw_vs;
  logic                  raw_vt;
  logic                  raw_vd;
  logic                  busy_vau0;
  logic                  busy_vlu;
  logic                  busy_vsu;
  logic                  dhazard;
  logic                  shazard;
  logic                  seqhazard;
  logic                  bhazard;

  // only writes whose first element is not out yet block a reader
  always_comb
  begin
    pend = wstate.val & wstate.head;
    for (int i = 0; i < `NUM_BANKS; i++)
    begin
      hit_vs[i] = (wstate.tags[i] == req.vs);
      hit_vt[i] = (wstate.tags[i] == req.vt);
      hit_vd[i] = (wstate.tags[i] == req.vd);
    end
    raw_vs = |(pend & hit_vs);
    raw_vt = |(pend & hit_vt);
    raw_vd = |(pend & hit_vd);
  end

  always_comb
  begin
    busy_vau0 = |(rstate.val & rstate.vau0) | |(wstate.val & wstate.vau0);
    busy_vlu  = |(wstate.val & wstate.vlu);
    busy_vsu  = |(rstate.val & rstate.vsu);
  end

  // per-unit operand use and port footprint
  always_comb
  begin
    seqhazard = slots[ptrs.plus1];
    case (req.op)
      hazard_pkg::OP_VIU:
      begin
        dhazard = raw_vs | raw_vd;
        shazard = 1'b0;
        bhazard = rstate.val[ptrs.plus2] | wstate.val[ptrs.viu_wptr];
      end
      hazard_pkg::OP_VAU0:
      begin
        dhazard = raw_vs | raw_vt | raw_vd;
        shazard = busy_vau0;
        bhazard = rstate.val[ptrs.plus2] | rstate.val[ptrs.plus3]
                | wstate.val[ptrs.vau0_wptr];
      end
      hazard_pkg::OP_VLU:
      begin
        dhazard = raw_vd;
        shazard = busy_vlu;
        bhazard = wstate.val[ptrs.plus2];
      end
      default:
      begin
        dhazard = raw_vt;
        shazard = busy_vsu;
        bhazard = rstate.val[ptrs.plus2];
      end
    endcase
  end

  assign ready = ~(dhazard | shazard | seqhazard | bhazard);
  assign fire  = req.valid & ready;
  assign op    = req.op;
  assign vd    = req.vd;

endmodule

`default_nettype wire

// ==== verilog/hazard_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "hazard_config.svh"

module hazard_top
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`BCNT_W-1:0]     bcnt,
  input  hazard_pkg::issue_req_t req,
  input  hazard_pkg::retire_t    retire,
  output logic                   ready,
  output logic                   fire
);

  hazard_pkg::ring_ptrs_t   ptrs;
  hazard_pkg::rport_state_t rstate;
  hazard_pkg::wport_state_t wstate;
  hazard_pkg::bank_vec_t    slots;
  hazard_pkg::unit_op_e     fire_op;
  hazard_pkg::reg_idx_t     fire_vd;

  bank_ring i_ring (
    .clk   (clk),
    .reset (reset),
    .bcnt  (bcnt),
    .ptrs  (ptrs)
  );

  rport_table i_rport (
    .clk   (clk),
    .reset (reset),
    .ptrs  (ptrs),
    .fire  (fire),
    .op    (fire_op),
    .rlast (retire.lane_rlast),
    .state (rstate)
  );

  wport_table i_wport (
    .clk        (clk),
    .reset      (reset),
    .ptrs       (ptrs),
    .fire       (fire),
    .op         (fire_op),
    .vd         (fire_vd),
    .expand_wen (retire.expand_wen),
    .wlast      (retire.lane_wlast),
    .state      (wstate)
  );

  seq_slot_table i_seq (
    .clk      (clk),
    .reset    (reset),
    .ptrs     (ptrs),
    .fire     (fire),
    .seq_last (retire.seq_last),
    .slots    (slots)
  );

  issue_check i_check (
    .req    (req),
    .ptrs   (ptrs),
    .rstate (rstate),
    .wstate (wstate),
    .slots  (slots),
    .ready  (ready),
    .fire   (fire),
    .op     (fire_op),
    .vd     (fire_vd)
  );

endmodule

`default_nettype wire

// ==== dv/hazard_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 5;
  localparam int FIELDS = 12;

  logic                   clk;
  logic                   reset;
  logic [3:0]             bcnt;
  hazard_pkg::issue_req_t req;
  hazard_pkg::retire_t    retire;
  logic                   ready;
  logic                   fire;

  // golden vectors, one entry per cycle
  string    vec_name [$];
  int       vec_bcnt [$];
  int       vec_valid [$];
  int       vec_op [$];
  int       vec_vs [$];
  int       vec_vt [$];
  int       vec_vd [$];
  int       vec_rlast [$];
  int       vec_wlast [$];
  int       vec_wen [$];
  int       vec_slast [$];
  int       vec_ready [$];

  int       num_lines;
  bit       loaded;
  bit       load_ok;
  int       checks;
  int       errors;
  int       test_errors;
  int       test_cycles;
  int       tests_run;
  int       tests_failed;

  hazard_top i_dut (
    .clk    (clk),
    .reset  (reset),
    .bcnt   (bcnt),
    .req    (req),
    .retire (retire),
    .ready  (ready),
    .fire   (fire)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic load_golden();
    int    fd;
    int    cnt;
    string line;
    string name;
    int    f [11];
    fd = $fopen("dv/hazard_golden.txt", "r");
    load_ok = (fd != 0);
    if (fd != 0)
    begin
      while ($fgets(line, fd) != 0)
      begin
        // blank lines and comment lines carry no vector
        if (line.len() > 1 && line[0] != "#")
        begin
          cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d", name,
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10]);
          if (cnt != FIELDS)
          begin
            $display("golden file line is malformed: %s", line);
            load_ok = 1'b0;
          end
          else
          begin
            vec_name.push_back(name);
            vec_bcnt.push_back(f[0]);
            vec_valid.push_back(f[1]);
            vec_op.push_back(f[2]);
            vec_vs.push_back(f[3]);
            vec_vt.push_back(f[4]);
            vec_vd.push_back(f[5]);
            vec_rlast.push_back(f[6]);
            vec_wlast.push_back(f[7]);
            vec_wen.push_back(f[8]);
            vec_slast.push_back(f[9]);
            vec_ready.push_back(f[10]);
          end
        end
      end
      $fclose(fd);
    end
    num_lines = vec_name.size();
    if (num_lines == 0)
      load_ok = 1'b0;
  endtask

  task automatic drive_vector(input int i);
    req.valid     = vec_valid[i][0];
    req.op        = hazard_pkg::unit_op_e'(vec_op[i][1:0]);
    req.vs        = vec_vs[i][4:0];
    req.vt        = vec_vt[i][4:0];
    req.vd        = vec_vd[i][4:0];
    retire.lane_rlast = vec_rlast[i][0];
    retire.lane_wlast = vec_wlast[i][0];
    retire.expand_wen = vec_wen[i][0];
    retire.seq_last   = vec_slast[i][0];
    bcnt          = vec_bcnt[i][3:0];
  endtask

  task automatic check_ready(input string name, input logic exp);
    checks++;
    if (ready !== exp)
    begin
      $display("MISMATCH %s ready: expected %0b, actual %0b", name, exp, ready);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_fire(input string name, input logic exp);
    checks++;
    if (fire !== exp)
    begin
      $display("MISMATCH %s fire: expected %0b, actual %0b", name, exp, fire);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errors == 0)
      $display("test %s: ok after %0d cycles", name, test_cycles);
    else
    begin
      $display("test %s: %0d errors in %0d cycles", name, test_errors, test_cycles);
      tests_failed++;
    end
    test_errors = 0;
    test_cycles = 0;
  endtask

  task automatic run_vectors();
    logic exp_ready;
    repeat (RESET_CYCLES) @(posedge clk);
    for (int i = 0; i < num_lines; i++)
    begin
      #1;
      reset = 1'b0;
      drive_vector(i);
      // sample well before the next edge
      #40;
      exp_ready = vec_ready[i][0];
      check_ready(vec_name[i], exp_ready);
      check_fire(vec_name[i], vec_valid[i][0] & exp_ready);
      test_cycles++;
      if (i == num_lines - 1 || vec_name[i + 1] != vec_name[i])
        report_test(vec_name[i]);
      @(posedge clk);
    end
  endtask

  initial
  begin
    reset  = 1'b1;
    bcnt   = 4'd8;
    req    = '0;
    retire = '0;
    loaded = 1'b0;
    checks = 0;
    errors = 0;
    test_errors  = 0;
    test_cycles  = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_golden();
    if (!load_ok)
    begin
      $display("golden file dv/hazard_golden.txt could not be read");
      $display("Result: FAILED");
      $finish;
    end
    else
    begin
      loaded = 1'b1;
      run_vectors();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0)
        $display("Result: PASSED");
      else
        $display("Result: FAILED");
      $finish;
    end
  end

  // limit scales with the vector count
  initial
  begin
    wait (loaded);
    #((num_lines + RESET_CYCLES) * 200);
    $display("timeout: vectors did not complete within %0d ns",
             (num_lines + RESET_CYCLES) * 200);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/hazard_golden.txt ====
# name bcnt valid op(0 viu,1 vau0,2 vlu,3 vsu) vs vt vd
# rlast wlast expand_wen seq_last expected_ready
viu_basic 8 1 0 1 0 2 0 0 0 0 1
viu_basic 8 1 0 3 0 5 0 0 0 1 1
viu_basic 8 0 0 0 0 0 1 0 0 1 1
viu_basic 8 0 0 0 0 0 1 0 0 0 1
viu_basic 8 0 0 0 0 0 0 1 0 0 1
viu_basic 8 0 0 0 0 0 0 1 0 0 1
vau0_raw 8 1 0 1 0 7 0 0 0 0 1
vau0_raw 8 1 1 7 3 9 0 0 0 1 0
vau0_raw 8 1 1 7 3 9 1 0 0 0 0
vau0_raw 8 1 1 7 3 9 0 0 0 0 0
vau0_raw 8 1 1 7 3 9 0 0 1 0 0
vau0_raw 8 1 1 7 3 9 0 0 0 0 1
vau0_busy 8 1 1 10 11 12 0 0 0 1 0
vau0_busy 8 1 1 10 11 12 1 0 0 0 0
vau0_busy 8 1 1 10 11 12 1 0 0 0 0
vau0_busy 8 1 1 10 11 12 0 0 0 0 0
vau0_busy 8 1 1 10 11 12 0 0 0 0 0
vau0_busy 8 1 1 10 11 12 0 1 0 0 0
vau0_busy 8 1 1 10 11 12 0 1 0 0 1
vau0_busy 8 0 0 0 0 0 0 0 0 1 0
vau0_busy 8 0 0 0 0 0 1 0 0 0 0
vau0_busy 8 0 0 0 0 0 1 0 0 0 1
vau0_busy 8 0 0 0 0 0 0 0 0 0 1
vau0_busy 8 0 0 0 0 0 0 0 0 0 1
vau0_busy 8 0 0 0 0 0 0 1 0 0 1
vsu_bank 5 1 0 1 0 2 0 0 0 0 1
vsu_bank 5 0 3 0 4 0 0 0 0 1 1
vsu_bank 5 0 3 0 4 0 0 0 0 0 1
vsu_bank 5 0 3 0 4 0 0 0 0 0 1
vsu_bank 5 0 3 0 4 0 0 1 0 0 1
vsu_bank 5 1 3 0 4 0 0 0 0 0 0
vsu_bank 5 0 3 0 4 0 0 0 0 0 1
vsu_bank 5 0 3 0 4 0 1 0 0 0 1
vsu_bank 5 0 3 0 4 0 0 0 0 0 1
vsu_bank 5 0 3 0 4 0 0 0 0 0 1
vsu_bank 5 1 3 0 4 0 0 0 0 0 1
vlu_seq 5 1 2 0 0 6 0 0 0 1 1
vlu_seq 5 0 0 8 0 9 1 0 0 0 1
vlu_seq 5 0 0 8 0 9 0 0 0 0 1
vlu_seq 5 0 0 8 0 9 0 0 0 0 0
vlu_seq 5 0 0 8 0 9 0 0 0 0 1
vlu_seq 5 1 0 8 0 9 0 0 0 0 0
vlu_seq 5 0 0 8 0 9 0 0 0 1 1
vlu_seq 5 0 0 8 0 9 0 1 0 0 1
vlu_seq 5 0 0 8 0 9 0 0 0 0 1
vlu_seq 5 0 0 8 0 9 0 0 0 0 1
vlu_seq 5 0 0 8 0 9 0 0 0 0 1
wrap_bcnt4 4 1 1 1 2 3 0 0 0 0 1
wrap_bcnt4 4 1 0 4 0 5 0 0 0 1 0
wrap_bcnt4 4 1 0 4 0 5 1 0 0 0 0
wrap_bcnt4 4 1 0 4 0 5 1 0 0 0 1
wrap_bcnt4 4 1 2 0 0 7 0 0 0 1 0
wrap_bcnt4 4 1 2 0 0 7 1 0 0 0 0
wrap_bcnt4 4 1 2 0 0 7 0 1 0 0 1
wrap_bcnt4 4 0 0 0 0 0 0 1 0 1 0
wrap_bcnt4 4 0 0 0 0 0 0 1 0 0 0
wrap_bcnt4 4 0 0 0 0 0 0 0 0 0 1

// ==== bank_hazard.f ====
+incdir+common
common/hazard_pkg.sv
verilog/bank_ring.sv
reservation/rport_table.sv
reservation/wport_table.sv
reservation/seq_slot_table.sv
verilog/issue_check.sv
verilog/hazard_top.sv
dv/hazard_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hazard checker testbench with Verilator

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f bank_hazard.f --top-module hazard_tb -o hazard_sim > build.log 2>&1 \
  && ./obj_dir/hazard_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete, see build.log and sim.log"

cat sim.log 2>/dev/null

grep -q "^Result: PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
